/* cart_loader/cart_loader.sv */
`timescale 1ns/1ps

module cart_loader (
  input  logic               clk_sys_42_95,
  input  logic               rst_n,
  input  logic               cart_download,
  input  logic               ioctl_wr,
  input  pce_pkg::rom_word_t ioctl_dout,
  input  logic               swap_bits,
  input  logic               rom_wb_ack,
  output logic               ioctl_wait,
  output logic               rom_wb_cyc,
  output logic               rom_wb_stb,
  output logic               rom_wb_we,
  output pce_pkg::rom_addr_t rom_wb_adr,
  output pce_pkg::rom_word_t rom_wb_dat,
  output logic [1:0]         rom_wb_sel,
  output pce_pkg::rom_size_t rom_size,
  output logic               rom_pop
);

  pce_pkg::loader_state_e state;
  pce_pkg::rom_addr_t     load_addr;
  pce_pkg::rom_word_t     swapped;
  logic                   old_download;
  logic                   prev_wr;
  logic                   wr_rise;
  logic                   wr_fall;
  logic                   download_rise;
  logic                   bus_start;

  // bit order reversed inside each byte, byte order kept
  always_comb begin
    swapped = ioctl_dout;
    if (swap_bits) begin
      for (int i = 0; i < 8; i++) begin
        swapped[i]     = ioctl_dout[7 - i];
        swapped[8 + i] = ioctl_dout[15 - i];
      end
    end
  end

  assign wr_rise       = ioctl_wr & ~prev_wr;
  assign wr_fall       = ~ioctl_wr & prev_wr;
  assign download_rise = cart_download & ~old_download;

  // new request only outside an open bus cycle
  assign bus_start = wr_rise && (state != pce_pkg::LOAD_BUS);

  always_ff @(posedge clk_sys_42_95 or negedge rst_n) begin
    if (!rst_n) begin
      old_download <= 1'b0;
      prev_wr      <= 1'b0;
    end else begin
      old_download <= cart_download;
      prev_wr      <= ioctl_wr;
    end
  end

  // download address, steps one word per write strobe
  always_ff @(posedge clk_sys_42_95 or negedge rst_n) begin
    if (!rst_n) begin
      load_addr <= '0;
    end else if (download_rise) begin
      load_addr <= '0;
    end else if (wr_fall) begin
      load_addr <= load_addr + 24'd2;
    end
  end

  // bus sequencing
  // release waits for the source to drop ioctl_wr
  always_ff @(posedge clk_sys_42_95 or negedge rst_n) begin
    if (!rst_n) begin
      state <= pce_pkg::LOAD_IDLE;
    end else begin
      case (state)
        pce_pkg::LOAD_IDLE: begin
          if (wr_rise) state <= pce_pkg::LOAD_BUS;
        end
        pce_pkg::LOAD_BUS: begin
          if (rom_wb_ack) state <= pce_pkg::LOAD_RELEASE;
        end
        pce_pkg::LOAD_RELEASE: begin
          if (wr_rise) state <= pce_pkg::LOAD_BUS;
          else if (!ioctl_wr) state <= pce_pkg::LOAD_IDLE;
        end
        default: state <= pce_pkg::LOAD_IDLE;
      endcase
    end
  end

  // address and data frozen for the whole cycle
  // counter may move on while ack is pending
  always_ff @(posedge clk_sys_42_95) begin
    if (bus_start) begin
      rom_wb_adr <= load_addr;
      rom_wb_dat <= swapped;
    end
  end

  assign rom_wb_cyc = (state == pce_pkg::LOAD_BUS);
  assign rom_wb_stb = rom_wb_cyc;
  assign rom_wb_we  = rom_wb_cyc;
  assign rom_wb_sel = 2'b11;
  // stall the source until the slave takes the word
  assign ioctl_wait = rom_wb_cyc;

  // 4 KB pages
  assign rom_size = load_addr[23:12];

  populous_detect u_populous_detect (
    .clk_sys_42_95 (clk_sys_42_95),
    .rst_n         (rst_n),
    .cart_download (cart_download),
    .word_strobe   (bus_start),
    .word_addr     (load_addr),
    .word_data     (swapped),
    .bank_sel      (load_addr[9]),
    .pop_flag      (rom_pop)
  );

endmodule

/* cart_loader/populous_detect.sv */
`timescale 1ns/1ps

module populous_detect (
  input  logic               clk_sys_42_95,
  input  logic               rst_n,
  input  logic               cart_download,
  input  logic               word_strobe,
  input  pce_pkg::rom_addr_t word_addr,
  input  pce_pkg::rom_word_t word_data,
  input  logic               bank_sel,
  output logic               pop_flag
);

  logic [1:0]         pop_bank;
  logic               old_download;
  logic               sig_loc;
  logic               check_en;
  pce_pkg::rom_word_t expected;

  // signature word for this offset, only four offsets checked
  always_comb begin
    check_en = 1'b1;
    expected = '0;
    case (word_addr[3:0])
      4'd6:    expected = pce_pkg::POP_SIG_6;
      4'd8:    expected = pce_pkg::POP_SIG_8;
      4'd10:   expected = pce_pkg::POP_SIG_10;
      4'd12:   expected = pce_pkg::POP_SIG_12;
      default: check_en = 1'b0;
    endcase
  end

  // either of the two header spots
  assign sig_loc = (word_addr[23:4] == pce_pkg::POP_TAG_LO) ||
                   (word_addr[23:4] == pce_pkg::POP_TAG_HI);

  // one flag per 8 KB bank, addr bit 13
  // assumed populous until a signature word misses
  always_ff @(posedge clk_sys_42_95 or negedge rst_n) begin
    if (!rst_n) begin
      old_download <= 1'b0;
      pop_bank     <= 2'b11;
    end else begin
      old_download <= cart_download;
      if (cart_download && !old_download) begin
        pop_bank <= 2'b11;
      end else if (word_strobe && sig_loc && check_en && (word_data != expected)) begin
        pop_bank[word_addr[13]] <= 1'b0;
      end
    end
  end

  assign pop_flag = pop_bank[bank_sel];

endmodule

/* common/pce_pkg.sv */
package pce_pkg;

  // rom side, byte address of the download stream
  typedef logic [23:0] rom_addr_t;

  // one 16-bit word from the download port, also the rom data word
  typedef logic [15:0] rom_word_t;

  // rom size in 4 KB pages
  typedef logic [11:0] rom_size_t;

  // nibble handed back to the console on a pad read
  typedef logic [3:0] joy_nibble_t;

  // multitap port number
  typedef logic [2:0] joy_port_t;

  // full 16-bit answer of one port before the nibble is picked
  typedef logic [15:0] pad_word_t;

  // console side of the backup ram, byte addressed
  typedef logic [10:0] bram_addr_t;
  typedef logic [7:0] bram_byte_t;

  // save file side, block number and word index in the block
  typedef logic [16:0] sd_lba_t;
  typedef logic [7:0] sd_buff_addr_t;
  typedef logic [15:0] save_word_t;

  // cart loader bus states
  typedef enum logic [1:0] {
    LOAD_IDLE,
    LOAD_BUS,
    LOAD_RELEASE
  } loader_state_e;

  // address bits 23..4 of the two signature spots
  localparam logic [19:0] POP_TAG_LO = 20'h001f2;
  localparam logic [19:0] POP_TAG_HI = 20'h00212;

  // expected words at offsets 6, 8, 10 and 12
  // spells "POPULOUS" as byte pairs
  localparam rom_word_t POP_SIG_6  = 16'h4f50;
  localparam rom_word_t POP_SIG_8  = 16'h5550;
  localparam rom_word_t POP_SIG_10 = 16'h4f4c;
  localparam rom_word_t POP_SIG_12 = 16'h5355;

  // empty multitap port, buttons all released
  localparam pad_word_t NO_PAD_WORD = 16'h0fff;

  // save blocks below this number live in internal ram
  localparam sd_lba_t BK_INT_BLOCKS = 17'd4;

endpackage

/* compile.f */
common/pce_pkg.sv
cart_loader/populous_detect.sv
cart_loader/cart_loader.sv
src/joypad_scanner.sv
src/backup_ram.sv
src/pce_io_bridge.sv
testbench/pce_io_bridge_assertions.sv
testbench/pce_io_bridge_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the bridge testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module pce_io_bridge_tb \
  -f compile.f -o pce_io_bridge_sim

# sim exit status is not trusted, the log decides
./obj_dir/pce_io_bridge_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
  echo "simulation reported failure"
  exit 1
fi
if ! grep -q "ALL TESTS PASSED" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
exit 0

/* src/backup_ram.sv */
`timescale 1ns/1ps

module backup_ram (
  input  logic                   clk_sys_42_95,
  input  pce_pkg::bram_addr_t    bram_addr,
  input  pce_pkg::bram_byte_t    bram_data,
  input  logic                   bram_wr,
  input  pce_pkg::sd_lba_t       sd_lba,
  input  pce_pkg::sd_buff_addr_t sd_buff_addr,
  input  pce_pkg::save_word_t    sd_buff_dout,
  input  logic                   sd_wr,
  output pce_pkg::bram_byte_t    bram_q,
  output pce_pkg::save_word_t    sd_buff_din
);

  logic [9:0] save_word_addr;
  logic       save_int;
  logic       save_wr;
  logic       save_int_q;
  logic       byte_sel_q;

  // low two block bits select the 512 byte quarter
  assign save_word_addr = {sd_lba[1:0], sd_buff_addr};

  // blocks past the internal area belong to external storage
  assign save_int = (sd_lba < pce_pkg::BK_INT_BLOCKS);
  assign save_wr  = sd_wr & save_int;

  // one 1K x 8 lane per byte of the save word
  // lane 0 holds even console bytes, lane 1 odd ones
  for (genvar lane = 0; lane < 2; lane++) begin : g_lane
    logic [7:0] mem [1024];
    logic [7:0] q_a;
    logic [7:0] q_b;

    always_ff @(posedge clk_sys_42_95) begin
      if (bram_wr && (bram_addr[0] == 1'(lane))) begin
        mem[bram_addr[10:1]] <= bram_data;
      end
      if (save_wr) begin
        mem[save_word_addr] <= sd_buff_dout[8 * lane +: 8];
      end
      q_a <= mem[bram_addr[10:1]];
      q_b <= mem[save_word_addr];
    end
  end

  // read side qualifiers follow the data by one cycle
  always_ff @(posedge clk_sys_42_95) begin
    byte_sel_q <= bram_addr[0];
    save_int_q <= save_int;
  end

  assign bram_q = byte_sel_q ? g_lane[1].q_a : g_lane[0].q_a;

  // outside the internal blocks the save port reads zero
  assign sd_buff_din = save_int_q ? {g_lane[1].q_b, g_lane[0].q_b} : '0;

endmodule

/* src/joypad_scanner.sv */
`timescale 1ns/1ps

module joypad_scanner (
  input  logic                 clk_sys_42_95,
  input  logic                 rst_n,
  input  logic                 button_a,
  input  logic                 button_b,
  input  logic                 button_select,
  input  logic                 button_start,
  input  logic                 dpad_up,
  input  logic                 dpad_down,
  input  logic                 dpad_left,
  input  logic                 dpad_right,
  input  logic                 multitap_en,
  input  logic                 six_button_en,
  input  logic                 joy_clr,
  input  logic                 joy_sel,
  output pce_pkg::joy_nibble_t joy_in
);

  pce_pkg::pad_word_t pad0_word;
  pce_pkg::pad_word_t pad_word;
  pce_pkg::joy_port_t joy_port;
  logic               clr_q;
  logic               sel_q;
  logic               clr_d;
  logic               clr_rise;
  logic               sel_rise;
  logic               high_buttons;

  // port 0 answer, console expects pressed = 0
  // upper nibble pair feeds the six-button id read
  assign pad0_word = {
    4'h0,
    4'hf,
    ~dpad_down,
    ~dpad_left,
    ~dpad_right,
    ~dpad_up,
    ~button_start,
    ~button_select,
    ~button_b,
    ~button_a
  };

  // only one real pad, the rest of the tap is empty
  assign pad_word = (joy_port == '0) ? pad0_word : pce_pkg::NO_PAD_WORD;

  assign clr_rise = clr_q & ~clr_d;
  // sel edge taken at the input so the port steps before the next pick
  assign sel_rise = joy_sel & ~sel_q;

  // console lines registered once, clr keeps one more stage of history
  always_ff @(posedge clk_sys_42_95 or negedge rst_n) begin
    if (!rst_n) begin
      clr_q <= 1'b0;
      sel_q <= 1'b0;
      clr_d <= 1'b0;
    end else begin
      clr_q <= joy_clr;
      sel_q <= joy_sel;
      clr_d <= clr_q;
    end
  end

  always_ff @(posedge clk_sys_42_95 or negedge rst_n) begin
    if (!rst_n) begin
      joy_in       <= '0;
      joy_port     <= '0;
      high_buttons <= 1'b0;
    end else if (clr_q) begin
      // clear phase, back to the first tap port
      joy_in   <= '0;
      joy_port <= '0;
      // six-button pads alternate normal and id scans
      if (clr_rise) high_buttons <= ~high_buttons & six_button_en;
    end else begin
      // nibble pick by scan half and sel
      joy_in <= pad_word[{high_buttons, sel_q, 2'b00} +: 4];
      if (sel_rise && multitap_en) joy_port <= joy_port + 3'd1;
    end
  end

endmodule

/* src/pce_io_bridge.sv */
`timescale 1ns/1ps

module pce_io_bridge (
  input  logic                   clk_sys_42_95,
  input  logic                   rst_n,
  // download port and rom write bus
  input  logic                   cart_download,
  input  logic                   ioctl_wr,
  input  pce_pkg::rom_word_t     ioctl_dout,
  input  logic                   swap_bits,
  output logic                   ioctl_wait,
  output logic                   rom_wb_cyc,
  output logic                   rom_wb_stb,
  output logic                   rom_wb_we,
  output pce_pkg::rom_addr_t     rom_wb_adr,
  output pce_pkg::rom_word_t     rom_wb_dat,
  output logic [1:0]             rom_wb_sel,
  input  logic                   rom_wb_ack,
  output pce_pkg::rom_size_t     rom_size,
  output logic                   rom_pop,
  // pad
  input  logic                   button_a,
  input  logic                   button_b,
  input  logic                   button_select,
  input  logic                   button_start,
  input  logic                   dpad_up,
  input  logic                   dpad_down,
  input  logic                   dpad_left,
  input  logic                   dpad_right,
  input  logic                   multitap_en,
  input  logic                   six_button_en,
  input  logic                   joy_clr,
  input  logic                   joy_sel,
  output pce_pkg::joy_nibble_t   joy_in,
  // backup ram, console and save file sides
  input  pce_pkg::bram_addr_t    bram_addr,
  input  pce_pkg::bram_byte_t    bram_data,
  input  logic                   bram_wr,
  output pce_pkg::bram_byte_t    bram_q,
  input  pce_pkg::sd_lba_t       sd_lba,
  input  pce_pkg::sd_buff_addr_t sd_buff_addr,
  input  pce_pkg::save_word_t    sd_buff_dout,
  input  logic                   sd_wr,
  output pce_pkg::save_word_t    sd_buff_din
);

  cart_loader u_cart_loader (
    .clk_sys_42_95 (clk_sys_42_95),
    .rst_n         (rst_n),
    .cart_download (cart_download),
    .ioctl_wr      (ioctl_wr),
    .ioctl_dout    (ioctl_dout),
    .swap_bits     (swap_bits),
    .rom_wb_ack    (rom_wb_ack),
    .ioctl_wait    (ioctl_wait),
    .rom_wb_cyc    (rom_wb_cyc),
    .rom_wb_stb    (rom_wb_stb),
    .rom_wb_we     (rom_wb_we),
    .rom_wb_adr    (rom_wb_adr),
    .rom_wb_dat    (rom_wb_dat),
    .rom_wb_sel    (rom_wb_sel),
    .rom_size      (rom_size),
    .rom_pop       (rom_pop)
  );

  joypad_scanner u_joypad_scanner (
    .clk_sys_42_95 (clk_sys_42_95),
    .rst_n         (rst_n),
    .button_a      (button_a),
    .button_b      (button_b),
    .button_select (button_select),
    .button_start  (button_start),
    .dpad_up       (dpad_up),
    .dpad_down     (dpad_down),
    .dpad_left     (dpad_left),
    .dpad_right    (dpad_right),
    .multitap_en   (multitap_en),
    .six_button_en (six_button_en),
    .joy_clr       (joy_clr),
    .joy_sel       (joy_sel),
    .joy_in        (joy_in)
  );

  backup_ram u_backup_ram (
    .clk_sys_42_95 (clk_sys_42_95),
    .bram_addr     (bram_addr),
    .bram_data     (bram_data),
    .bram_wr       (bram_wr),
    .sd_lba        (sd_lba),
    .sd_buff_addr  (sd_buff_addr),
    .sd_buff_dout  (sd_buff_dout),
    .sd_wr         (sd_wr),
    .bram_q        (bram_q),
    .sd_buff_din   (sd_buff_din)
  );

endmodule

/* testbench/pce_io_bridge_assertions.sv */
`timescale 1ns/1ps

module pce_io_bridge_assertions (
  input logic               clk_sys_42_95,
  input logic               rst_n,
  input logic               rom_wb_cyc,
  input logic               rom_wb_stb,
  input logic               rom_wb_ack,
  input logic               ioctl_wait,
  input pce_pkg::rom_addr_t rom_wb_adr
);

  // strobe only inside a bus cycle
  stb_in_cyc: assert property (@(posedge clk_sys_42_95) disable iff (!rst_n)
    rom_wb_stb |-> rom_wb_cyc)
    else $error("rom_wb_stb high without rom_wb_cyc");

  // source stalled for the whole cycle
  cyc_holds_wait: assert property (@(posedge clk_sys_42_95) disable iff (!rst_n)
    rom_wb_cyc |-> ioctl_wait)
    else $error("rom_wb_cyc high while ioctl_wait low");

  // no ack yet, so cycle and address hold
  cyc_stable_to_ack: assert property (@(posedge clk_sys_42_95) disable iff (!rst_n)
    (rom_wb_cyc && !rom_wb_ack) |=> (rom_wb_cyc && $stable(rom_wb_adr)))
    else $error("rom_wb_cyc or rom_wb_adr changed before ack");

  // bus idle while in reset
  idle_in_reset: assert property (@(posedge clk_sys_42_95)
    !rst_n |-> (!rom_wb_cyc && !ioctl_wait))
    else $error("bus active during reset");

endmodule

bind cart_loader pce_io_bridge_assertions u_bus_checks (.*);

/* testbench/pce_io_bridge_tb.sv */
`timescale 1ns/1ps

module pce_io_bridge_tb;

  logic clk_sys_42_95 = 1'b0;
  logic rst_n, cart_download, ioctl_wr, swap_bits;
  logic rom_wb_ack = 1'b0;
  pce_pkg::rom_word_t ioctl_dout;
  logic ioctl_wait, rom_wb_cyc, rom_wb_stb, rom_wb_we, rom_pop;
  pce_pkg::rom_addr_t rom_wb_adr;
  pce_pkg::rom_word_t rom_wb_dat;
  logic [1:0] rom_wb_sel;
  pce_pkg::rom_size_t rom_size;
  logic button_a, button_b, button_select, button_start;
  logic dpad_up, dpad_down, dpad_left, dpad_right;
  logic multitap_en, six_button_en, joy_clr, joy_sel;
  pce_pkg::joy_nibble_t joy_in;
  pce_pkg::bram_addr_t bram_addr;
  pce_pkg::bram_byte_t bram_data, bram_q;
  logic bram_wr, sd_wr;
  pce_pkg::sd_lba_t sd_lba;
  pce_pkg::sd_buff_addr_t sd_buff_addr;
  pce_pkg::save_word_t sd_buff_dout, sd_buff_din;

  // slave side record of every completed write
  pce_pkg::rom_word_t wb_mem [pce_pkg::rom_addr_t];
  int wb_count = 0;
  int seed = 57;
  int ack_delay = 0;
  int checks = 0;
  int errors = 0;
  int timeouts = 0;
  pce_pkg::rom_addr_t next_addr;
  logic swap_on;

  pce_io_bridge dut0 (.*);

  always #20 clk_sys_42_95 = ~clk_sys_42_95;

  // wishbone slave, random 0..3 cycle ack latency
  always @(posedge clk_sys_42_95) begin
    if (rom_wb_ack) begin
      rom_wb_ack <= 1'b0;
    end else if (rom_wb_cyc && rom_wb_stb) begin
      if (ack_delay == 0) begin
        rom_wb_ack <= 1'b1;
        wb_mem[rom_wb_adr] = rom_wb_dat;
        wb_count++;
        check_bus_ctl(rom_wb_we, rom_wb_sel);
        ack_delay = $random(seed) & 3;
      end else begin
        ack_delay--;
      end
    end
  end

  // mirror each byte bitwise
  function automatic pce_pkg::rom_word_t reverse_bits_in_bytes(input pce_pkg::rom_word_t w);
    pce_pkg::rom_word_t r;
    for (int b = 0; b < 16; b++) begin
      r[b] = w[(b & 8) + 7 - (b & 7)];
    end
    return r;
  endfunction

  task automatic report_mismatch(input string what, input logic [31:0] got, exp);
    $display("** Error at %0t ns: %s got %h expected %h", $time, what, got, exp);
    errors++;
  endtask

  // every rom write is a full word write
  task automatic check_bus_ctl(input logic got_we, input logic [1:0] got_sel);
    checks++;
    if (got_we !== 1'b1) report_mismatch("rom_wb_we", 32'(got_we), 32'h1);
    if (got_sel !== 2'b11) report_mismatch("rom_wb_sel", 32'(got_sel), 32'h3);
  endtask

  task automatic check_rom_word(input string what, input pce_pkg::rom_word_t got, exp);
    checks++;
    if (got !== exp) report_mismatch(what, 32'(got), 32'(exp));
  endtask

  task automatic check_rom_status(input pce_pkg::rom_size_t got_size, exp_size,
                                  input logic got_pop, exp_pop);
    checks++;
    if (got_size !== exp_size) report_mismatch("rom_size", 32'(got_size), 32'(exp_size));
    if (got_pop !== exp_pop) report_mismatch("rom_pop", 32'(got_pop), 32'(exp_pop));
  endtask

  task automatic check_joy(input pce_pkg::joy_nibble_t got, exp);
    checks++;
    if (got !== exp) report_mismatch("joy_in", 32'(got), 32'(exp));
  endtask

  task automatic check_bram(input pce_pkg::bram_byte_t got, exp);
    checks++;
    if (got !== exp) report_mismatch("bram_q", 32'(got), 32'(exp));
  endtask

  task automatic check_save(input pce_pkg::save_word_t got, exp);
    checks++;
    if (got !== exp) report_mismatch("sd_buff_din", 32'(got), 32'(exp));
  endtask

  task automatic wait_for_wait_level(input logic level);
    int n;
    n = 0;
    while (ioctl_wait !== level && n < 64) begin
      @(posedge clk_sys_42_95);
      n++;
    end
    if (ioctl_wait !== level) begin
      $display("timeout: ioctl_wait did not go to %0b at %0t ns", level, $time);
      timeouts++;
    end
  endtask

  // new download, address back to 0 and fresh slave record
  task automatic start_download(input logic swap);
    @(posedge clk_sys_42_95);
    cart_download <= 1'b0;
    swap_bits     <= swap;
    @(posedge clk_sys_42_95);
    cart_download <= 1'b1;
    repeat (2) @(posedge clk_sys_42_95);
    wb_mem.delete();
    wb_count  = 0;
    next_addr = '0;
    swap_on   = swap;
  endtask

  task automatic load_word(input pce_pkg::rom_word_t data);
    pce_pkg::rom_word_t exp;
    int expected_count;
    exp = swap_on ? reverse_bits_in_bytes(data) : data;
    expected_count = wb_count + 1;
    @(posedge clk_sys_42_95);
    ioctl_dout <= data;
    ioctl_wr   <= 1'b1;
    wait_for_wait_level(1'b1);
    if (timeouts == 0) wait_for_wait_level(1'b0);
    @(posedge clk_sys_42_95);
    ioctl_wr <= 1'b0;
    repeat (2) @(posedge clk_sys_42_95);
    checks++;
    if (wb_count != expected_count) begin
      report_mismatch("write count", 32'(wb_count), 32'(expected_count));
    end else if (!wb_mem.exists(next_addr)) begin
      $display("no wishbone write seen at address %h by %0t ns", next_addr, $time);
      errors++;
    end else begin
      check_rom_word("rom_wb_dat", wb_mem[next_addr], exp);
    end
    next_addr = next_addr + 24'd2;
  endtask

  // buttons bits 7..0 are down left right up start select b a, pressed = 1
  task automatic scan_pad(input logic [7:0] buttons, input logic mtap, six, clr, sel,
                          input pce_pkg::joy_nibble_t exp);
    @(posedge clk_sys_42_95);
    {dpad_down, dpad_left, dpad_right, dpad_up} <= buttons[7:4];
    {button_start, button_select, button_b, button_a} <= buttons[3:0];
    multitap_en   <= mtap;
    six_button_en <= six;
    joy_clr       <= clr;
    joy_sel       <= sel;
    // two cycles of settling, sampled at the third edge
    repeat (3) @(posedge clk_sys_42_95);
    check_joy(joy_in, exp);
  endtask

  task automatic save_write(input pce_pkg::sd_lba_t lba, input pce_pkg::sd_buff_addr_t a,
                            input pce_pkg::save_word_t d);
    @(posedge clk_sys_42_95);
    sd_lba       <= lba;
    sd_buff_addr <= a;
    sd_buff_dout <= d;
    sd_wr        <= 1'b1;
    @(posedge clk_sys_42_95);
    sd_wr <= 1'b0;
  endtask

  task automatic save_read(input pce_pkg::sd_lba_t lba, input pce_pkg::sd_buff_addr_t a,
                           input pce_pkg::save_word_t exp);
    @(posedge clk_sys_42_95);
    sd_lba       <= lba;
    sd_buff_addr <= a;
    repeat (2) @(posedge clk_sys_42_95);
    check_save(sd_buff_din, exp);
  endtask

  task automatic console_write(input pce_pkg::bram_addr_t a, input pce_pkg::bram_byte_t d);
    @(posedge clk_sys_42_95);
    bram_addr <= a;
    bram_data <= d;
    bram_wr   <= 1'b1;
    @(posedge clk_sys_42_95);
    bram_wr <= 1'b0;
  endtask

  task automatic console_read(input pce_pkg::bram_addr_t a, input pce_pkg::bram_byte_t exp);
    @(posedge clk_sys_42_95);
    bram_addr <= a;
    repeat (2) @(posedge clk_sys_42_95);
    check_bram(bram_q, exp);
  endtask

  initial begin
    int fd;
    int code;
    string line;
    logic [7:0] op;
    logic [31:0] f1, f2, f3, f4, f5, f6;
    rst_n = 1'b0;
    cart_download = 1'b0;
    ioctl_wr = 1'b0;
    ioctl_dout = '0;
    swap_bits = 1'b0;
    {button_a, button_b, button_select, button_start} = '0;
    {dpad_up, dpad_down, dpad_left, dpad_right} = '0;
    {multitap_en, six_button_en, joy_clr, joy_sel} = '0;
    bram_addr = '0;
    bram_data = '0;
    bram_wr = 1'b0;
    sd_lba = '0;
    sd_buff_addr = '0;
    sd_buff_dout = '0;
    sd_wr = 1'b0;
    next_addr = '0;
    swap_on = 1'b0;
    repeat (10) @(posedge clk_sys_42_95);
    rst_n <= 1'b1;
    @(posedge clk_sys_42_95);
    // idle bus and cleared pad latch out of reset
    check_joy(joy_in, 4'h0);
    check_rom_status(rom_size, 12'h000, rom_pop, 1'b1);
    fd = $fopen("testbench/pce_io_bridge_vectors.txt", "r");
    if (fd == 0) begin
      $display("could not open the vector file");
      timeouts++;
    end
    while (fd != 0 && !$feof(fd) && timeouts == 0) begin
      line = "";
      code = $fgets(line, fd);
      if (code == 0 || line.len() < 2 || line[0] == "#") continue;
      code = $sscanf(line, "%c %h %h %h %h %h %h", op, f1, f2, f3, f4, f5, f6);
      case (op)
        "S": start_download(f1[0]);
        "W": load_word(f1[15:0]);
        "F": begin
          for (int i = 0; i < int'(f1); i++) begin
            load_word(f2[15:0]);
            if (timeouts != 0) break;
          end
        end
        "R": begin
          @(posedge clk_sys_42_95);
          check_rom_status(rom_size, f1[11:0], rom_pop, f2[0]);
        end
        "P": scan_pad(f1[7:0], f2[0], f3[0], f4[0], f5[0], f6[3:0]);
        "V": save_write(f1[16:0], f2[7:0], f3[15:0]);
        "Q": save_read(f1[16:0], f2[7:0], f3[15:0]);
        "C": console_write(f1[10:0], f2[7:0]);
        "K": console_read(f1[10:0], f2[7:0]);
        default: $display("unknown vector record skipped: %s", line);
      endcase
    end
    if (fd != 0) $fclose(fd);
    $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

/* testbench/pce_io_bridge_vectors.txt */
# op and hex fields: S swap | W data | F count data | R size pop
# P buttons mtap six clr sel expect | V lba addr data | Q lba addr expect | C addr data | K addr expect
S 1
W 1234
W 80c1
W 00ff
R 000 1
S 0
F f93 0000
W 4f50
W 5550
W 4f4c
W 5355
F 69 0000
R 002 1
S 0
F f93 0000
W 4f50
W 1111
W 4f4c
W 5355
R 001 1
F 69 0000
R 002 0
S 0
R 000 1
P 25 0 0 0 0 a
P 25 0 0 0 1 d
P 9a 0 0 0 0 5
P 9a 0 0 0 1 6
P 9a 1 0 1 0 0
P 9a 1 0 0 0 5
P 9a 1 0 0 1 f
P 9a 1 0 0 0 f
P 9a 1 0 0 1 f
P 9a 0 1 1 0 0
P 9a 0 1 0 0 f
P 9a 0 1 0 1 0
P 9a 0 1 1 0 0
P 9a 0 1 0 0 5
P 9a 0 1 0 1 6
V 1 10 beef
K 220 ef
K 221 be
C 4 34
C 5 12
Q 0 02 1234
V 0 10 5a5a
V 4 10 aaaa
Q 0 10 5a5a
Q 4 10 0000
